/* sim.f */
source/kernel_pkg.sv
source/sync_fifo.sv
source/host_regs.sv
source/axi_write_master.sv
source/nvme_sq.sv
source/kernel_top.sv
bench/kernel_tb.sv

/* bench/kernel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_tb;

  localparam int host_ops   = 320; // rough count of host accesses over all tests
  localparam int max_cycles = 40 * host_ops + 2000;

  logic                          clk;
  logic                          rstn;
  logic                          host_en;
  logic [3:0]                    host_we;
  logic [kernel_pkg::addr_w-1:0] host_addr;
  logic [kernel_pkg::word_w-1:0] host_din;
  logic [kernel_pkg::word_w-1:0] host_dout;
  logic [63:0]                   awaddr;
  logic [2:0]                    awsize;
  logic [1:0]                    awburst;
  logic [7:0]                    awlen;
  logic [3:0]                    awid;
  logic                          awvalid;
  logic                          awready;
  logic [127:0]                  wdata;
  logic [15:0]                   wstrb;
  logic                          wlast;
  logic                          wvalid;
  logic                          wready;
  logic                          bvalid;
  logic [3:0]                    bid;
  logic [1:0]                    bresp;
  logic                          bready;

  integer seed       = 32'h8804;
  integer slave_seed = 32'h8804; // separate stream for the slave
  int     errors     = 0;
  int     checks     = 0;
  int     cycles     = 0;
  int     aw_seen    = 0;
  int     w_seen     = 0;
  int     b_issued   = 0;
  logic   b_fire     = 1'b0;

  logic [66:0]  exp_aw[$]; // {size, addr}
  logic [143:0] exp_w[$];  // {strb, data}
  logic [5:0]   exp_b[$];  // {id, resp}

  kernel_top dut_i (
    .clk(clk), .rstn(rstn),
    .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
    .host_din(host_din), .host_dout(host_dout),
    .k2o_awaddr(awaddr), .k2o_awsize(awsize), .k2o_awburst(awburst),
    .k2o_awlen(awlen), .k2o_awid(awid), .k2o_awvalid(awvalid), .k2o_awready(awready),
    .k2o_wdata(wdata), .k2o_wstrb(wstrb), .k2o_wlast(wlast),
    .k2o_wvalid(wvalid), .k2o_wready(wready),
    .k2o_bvalid(bvalid), .k2o_bid(bid), .k2o_bresp(bresp), .k2o_bready(bready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout after %0d cycles, a test never finished (%0d errors)", cycles, errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // starts on a falling edge and leaves two idle cycles for the strobes
  task automatic host_write(input logic [14:0] addr, input logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = addr;
    host_din  = data;
    @(negedge clk);
    host_en = 1'b0;
    host_we = 4'h0;
    repeat (2) @(negedge clk);
  endtask

  task automatic host_read(input logic [14:0] addr, output logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'h0;
    host_addr = addr;
    @(negedge clk);
    host_en = 1'b0;
    data    = host_dout; // loaded on the rising edge just passed
  endtask

  // inputs set here hold through the next rising edge
  always @(negedge clk) begin : slave_model
    logic [31:0]  r;
    logic [66:0]  ea;
    logic [143:0] ew;
    r = $random(slave_seed);
    if (rstn) begin
      if (b_fire) bvalid = 1'b0;
      b_fire = 1'b0;
      if (!bvalid && b_issued < aw_seen && b_issued < w_seen && r[2]) begin
        bvalid = 1'b1;
        bid    = r[7:4];
        bresp  = r[9:8];
        b_issued++;
      end
      if (bvalid && bready) begin
        b_fire = 1'b1;
        exp_b.push_back({bid, bresp});
      end
      awready = r[0];
      wready  = r[1];
      if (awvalid && awready) begin
        if (exp_aw.size() == 0) begin
          errors++;
          $display("write address beat arrived with no push outstanding");
        end else begin
          ea = exp_aw.pop_front();
          compare("awaddr", awaddr, ea[63:0]);
          compare("awsize", awsize, ea[66:64]);
          compare("awburst", awburst, 2'b01); // INCR
          compare("awlen", awlen, 8'h00);
          compare("awid", awid, 4'h1);
          aw_seen++;
        end
      end
      if (wvalid && wready) begin
        if (exp_w.size() == 0) begin
          errors++;
          $display("write data beat arrived with no push outstanding");
        end else begin
          ew = exp_w.pop_front();
          compare("wdata", wdata, ew[127:0]);
          compare("wstrb", wstrb, ew[143:128]);
          compare("wlast", wlast, 1'b1);
          w_seen++;
        end
      end
    end
  end

  initial begin
    logic [31:0]  rd;
    logic [31:0]  words[8];
    logic [63:0]  addr;
    logic [127:0] data;
    logic [31:0]  strb;
    logic [31:0]  lba;
    logic [31:0]  dptr;
    logic [31:0]  cmdw;
    logic [31:0]  sqe[5];
    logic [31:0]  mark;
    logic [15:0]  cnt;
    int           n_pairs;
    int           popped;
    rstn      = 1'b0;
    host_en   = 1'b0;
    host_we   = 4'h0;
    host_addr = '0;
    host_din  = '0;
    awready   = 1'b0;
    wready    = 1'b0;
    bvalid    = 1'b0;
    bid       = 4'h0;
    bresp     = 2'b00;
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    // staging round trip
    for (int i = 0; i < 8; i++) begin
      words[i] = $random(seed);
      host_write(kernel_pkg::reg_stage_base + 4 * i, words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      host_read(kernel_pkg::reg_stage_base + 4 * i, rd);
      compare("stage word", rd, words[i]);
    end

    // expected beats queued before each push
    n_pairs = 9 + ($random(seed) & 3);
    for (int i = 0; i < n_pairs; i++) begin
      addr = {$random(seed), $random(seed)};
      rd   = $random(seed);
      host_write(kernel_pkg::reg_stage_base, addr[31:0]);
      host_write(kernel_pkg::reg_stage_base + 4, addr[63:32]);
      host_write(kernel_pkg::reg_stage_base + 8, rd); // size in bits 2:0
      exp_aw.push_back({rd[2:0], addr});
      host_write(kernel_pkg::reg_aw_push, 32'h1);
      data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      strb = $random(seed);
      for (int k = 0; k < 4; k++) begin
        host_write(kernel_pkg::reg_stage_base + 4 * k, data[32*k +: 32]);
      end
      host_write(kernel_pkg::reg_stage_base + 16, strb);
      exp_w.push_back({strb[15:0], data});
      host_write(kernel_pkg::reg_w_push, 32'h1);
    end
    while (aw_seen < n_pairs || w_seen < n_pairs) @(negedge clk);

    // poll and pop responses in arrival order
    popped = 0;
    while (popped < n_pairs) begin
      host_read(kernel_pkg::reg_b_status, rd);
      if (rd[0]) begin
        host_write(kernel_pkg::reg_b_pop, 32'h1);
        host_read(kernel_pkg::reg_stage_base, rd);
        if (exp_b.size() == 0) begin
          errors++;
          $display("B FIFO held a response the slave never sent");
        end else begin
          compare("b entry", rd, {26'h0, exp_b.pop_front()});
        end
        popped++;
      end
    end

    // command submission
    cnt = 16'd0;
    for (int i = 0; i < 4; i++) begin
      lba  = $random(seed);
      dptr = $random(seed);
      cmdw = $random(seed);
      host_write(kernel_pkg::reg_lba, lba);
      host_write(kernel_pkg::reg_dptr, dptr);
      host_write(kernel_pkg::reg_cmd, cmdw);
      host_write(kernel_pkg::reg_submit, 32'h1);
      sqe[0] = {cnt, 8'h00, cmdw[7:0]};
      sqe[1] = 32'd1;
      sqe[2] = dptr;
      sqe[3] = lba;
      sqe[4] = {16'h0, cmdw[31:16]};
      cnt++;
      host_read(kernel_pkg::reg_sq_ptr, rd);
      compare("sq_ptr", rd, {cnt, cnt});
      host_write(kernel_pkg::reg_sq_pop, 32'h1);
      for (int k = 0; k < 5; k++) begin
        host_read(kernel_pkg::reg_stage_base + 4 * k, rd);
        compare("sqe word", rd, sqe[k]);
      end
    end

    // 17th submit and 17th pop must be dropped
    host_write(kernel_pkg::reg_sq_clear, 32'h1);
    host_read(kernel_pkg::reg_sq_ptr, rd);
    compare("sq_ptr", rd, 32'h0);
    for (int i = 0; i < 17; i++) host_write(kernel_pkg::reg_submit, 32'h1);
    host_read(kernel_pkg::reg_sq_ptr, rd);
    compare("sq_ptr", rd, {16'd16, 16'd16});
    for (int i = 0; i < 16; i++) begin
      host_write(kernel_pkg::reg_sq_pop, 32'h1);
      host_read(kernel_pkg::reg_stage_base, rd);
      compare("sqe cdw0", rd, {16'(i), 8'h00, cmdw[7:0]});
    end
    mark = $random(seed);
    host_write(kernel_pkg::reg_stage_base, mark); // must survive the empty pop
    host_write(kernel_pkg::reg_sq_pop, 32'h1);
    host_read(kernel_pkg::reg_stage_base, rd);
    compare("stage after empty pop", rd, mark);
    host_write(kernel_pkg::reg_sq_clear, 32'h1);
    host_read(kernel_pkg::reg_sq_ptr, rd);
    compare("sq_ptr", rd, 32'h0);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/kernel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_top (
  input  wire logic                                clk,
  input  wire logic                                rstn,
  input  wire logic                                host_en,
  input  wire logic [3:0]                          host_we,
  input  wire logic [kernel_pkg::addr_w-1:0]       host_addr,
  input  wire logic [kernel_pkg::word_w-1:0]       host_din,
  output logic [kernel_pkg::word_w-1:0]            host_dout,
  output logic [kernel_pkg::axi_addr_w-1:0]        k2o_awaddr,
  output logic [kernel_pkg::axi_size_w-1:0]        k2o_awsize,
  output logic [1:0]                               k2o_awburst,
  output logic [7:0]                               k2o_awlen,
  output logic [kernel_pkg::axi_id_w-1:0]          k2o_awid,
  output logic                                     k2o_awvalid,
  input  wire logic                                k2o_awready,
  output logic [kernel_pkg::axi_data_w-1:0]        k2o_wdata,
  output logic [kernel_pkg::axi_strb_w-1:0]        k2o_wstrb,
  output logic                                     k2o_wlast,
  output logic                                     k2o_wvalid,
  input  wire logic                                k2o_wready,
  input  wire logic                                k2o_bvalid,
  input  wire logic [kernel_pkg::axi_id_w-1:0]     k2o_bid,
  input  wire logic [kernel_pkg::axi_resp_w-1:0]   k2o_bresp,
  output logic                                     k2o_bready
);

  kernel_pkg::staging_t                  stage;
  logic                                  aw_push;
  logic                                  w_push;
  logic                                  b_pop;
  logic                                  b_valid;
  logic [kernel_pkg::axi_id_w-1:0]       b_id;
  logic [kernel_pkg::axi_resp_w-1:0]     b_resp;
  logic                                  lba_wr;
  logic                                  dptr_wr;
  logic                                  cmd_wr;
  logic                                  submit;
  logic                                  sq_clear;
  logic                                  sq_pop;
  logic [kernel_pkg::word_w-1:0]         field;
  logic [15:0]                           command_id;
  logic [15:0]                           head_ptr;
  logic                                  pop_valid;
  logic [kernel_pkg::sqe_w-1:0]          pop_entry;

  host_regs host_regs_i (
    .clk(clk), .rstn(rstn),
    .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
    .host_din(host_din), .host_dout(host_dout),
    .aw_push(aw_push), .w_push(w_push), .stage(stage), .b_pop(b_pop),
    .b_valid(b_valid), .b_id(b_id), .b_resp(b_resp),
    .lba_wr(lba_wr), .dptr_wr(dptr_wr), .cmd_wr(cmd_wr), .submit(submit),
    .sq_clear(sq_clear), .sq_pop(sq_pop), .field(field),
    .command_id(command_id), .head_ptr(head_ptr),
    .pop_valid(pop_valid), .pop_entry(pop_entry)
  );

  axi_write_master axi_write_master_i (
    .clk(clk), .rstn(rstn),
    .aw_push(aw_push), .w_push(w_push), .stage(stage), .b_pop(b_pop),
    .awaddr(k2o_awaddr), .awsize(k2o_awsize), .awburst(k2o_awburst),
    .awlen(k2o_awlen), .awid(k2o_awid), .awvalid(k2o_awvalid), .awready(k2o_awready),
    .wdata(k2o_wdata), .wstrb(k2o_wstrb), .wlast(k2o_wlast),
    .wvalid(k2o_wvalid), .wready(k2o_wready),
    .bvalid(k2o_bvalid), .bid(k2o_bid), .bresp(k2o_bresp), .bready(k2o_bready),
    .b_valid(b_valid), .b_id(b_id), .b_resp(b_resp)
  );

  nvme_sq nvme_sq_i (
    .clk(clk), .rstn(rstn),
    .lba_wr(lba_wr), .dptr_wr(dptr_wr), .cmd_wr(cmd_wr), .submit(submit),
    .sq_clear(sq_clear), .sq_pop(sq_pop), .field(field),
    .command_id(command_id), .head_ptr(head_ptr),
    .pop_valid(pop_valid), .pop_entry(pop_entry)
  );

endmodule

`default_nettype wire

/* source/nvme_sq.sv */
`timescale 1ns/1ps
`default_nettype none

module nvme_sq (
  input  wire logic                          clk,
  input  wire logic                          rstn,
  input  wire logic                          lba_wr,
  input  wire logic                          dptr_wr,
  input  wire logic                          cmd_wr,
  input  wire logic                          submit,
  input  wire logic                          sq_clear,
  input  wire logic                          sq_pop,
  input  wire logic [kernel_pkg::word_w-1:0] field,
  output logic [15:0]                        command_id,
  output logic [15:0]                        head_ptr,
  output logic                               pop_valid,
  output logic [kernel_pkg::sqe_w-1:0]       pop_entry
);

  logic [kernel_pkg::word_w-1:0] lba;
  logic [kernel_pkg::word_w-1:0] dptr;
  logic [7:0]                    opcode;
  logic [15:0]                   nlb;
  kernel_pkg::staging_t          cmd;
  logic                          sq_wready;
  logic                          sq_rvalid;
  logic [kernel_pkg::sqe_w-1:0]  sq_rdata;

  always_ff @(posedge clk) begin
    if (lba_wr) lba <= field;
    if (dptr_wr) dptr <= field;
    if (cmd_wr) begin
      opcode <= field[7:0];
      nlb    <= field[31:16]; // block count in the upper half
    end
  end

  // command under construction, id taken at submit time
  always_comb begin
    cmd          = '0;
    cmd.sqe.nlb  = nlb;
    cmd.sqe.lba  = lba;
    cmd.sqe.dptr = dptr;
    cmd.sqe.nsid = kernel_pkg::nvme_nsid;
    cmd.sqe.cdw0 = {command_id, 8'h00, opcode};
  end

  sync_fifo #(
    .width      (kernel_pkg::sqe_w),
    .depth_log2 (kernel_pkg::sq_depth_log2)
  ) sq_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (submit),
    .wdata  (cmd[kernel_pkg::sqe_w-1:0]),
    .wready (sq_wready),
    .rvalid (sq_rvalid),
    .rdata  (sq_rdata),
    .rready (sq_pop)
  );

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      command_id <= 16'd0;
      head_ptr   <= 16'd0;
      pop_valid  <= 1'b0;
    end else begin
      pop_valid <= sq_pop && sq_rvalid;
      if (sq_clear) begin
        command_id <= 16'd0;
        head_ptr   <= 16'd0;
      end else if (submit && sq_wready) begin // full queue drops the submit
        command_id <= command_id + 16'd1;
        head_ptr   <= head_ptr + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sq_pop && sq_rvalid) pop_entry <= sq_rdata;
  end

endmodule

`default_nettype wire

/* source/axi_write_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_master (
  input  wire logic                                clk,
  input  wire logic                                rstn,
  input  wire logic                                aw_push,
  input  wire logic                                w_push,
  input  wire kernel_pkg::staging_t                stage,
  input  wire logic                                b_pop,
  output logic [kernel_pkg::axi_addr_w-1:0]        awaddr,
  output logic [kernel_pkg::axi_size_w-1:0]        awsize,
  output logic [1:0]                               awburst,
  output logic [7:0]                               awlen,
  output logic [kernel_pkg::axi_id_w-1:0]          awid,
  output logic                                     awvalid,
  input  wire logic                                awready,
  output logic [kernel_pkg::axi_data_w-1:0]        wdata,
  output logic [kernel_pkg::axi_strb_w-1:0]        wstrb,
  output logic                                     wlast,
  output logic                                     wvalid,
  input  wire logic                                wready,
  input  wire logic                                bvalid,
  input  wire logic [kernel_pkg::axi_id_w-1:0]     bid,
  input  wire logic [kernel_pkg::axi_resp_w-1:0]   bresp,
  output logic                                     bready,
  output logic                                     b_valid,
  output logic [kernel_pkg::axi_id_w-1:0]          b_id,
  output logic [kernel_pkg::axi_resp_w-1:0]        b_resp
);

  logic [kernel_pkg::axi_size_w+kernel_pkg::axi_addr_w-1:0] aw_rdata;
  logic [kernel_pkg::axi_strb_w+kernel_pkg::axi_data_w-1:0] w_rdata;
  logic [kernel_pkg::axi_id_w+kernel_pkg::axi_resp_w-1:0]   b_rdata;

  // a push into a full FIFO is lost
  sync_fifo #(
    .width      (kernel_pkg::axi_size_w + kernel_pkg::axi_addr_w),
    .depth_log2 (kernel_pkg::fifo_depth_log2)
  ) aw_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  ({stage.aw.size, stage.aw.addr}),
    .wready (),
    .rvalid (awvalid),
    .rdata  (aw_rdata),
    .rready (awready)
  );

  sync_fifo #(
    .width      (kernel_pkg::axi_strb_w + kernel_pkg::axi_data_w),
    .depth_log2 (kernel_pkg::fifo_depth_log2)
  ) w_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  ({stage.w.strb, stage.w.data}),
    .wready (),
    .rvalid (wvalid),
    .rdata  (w_rdata),
    .rready (wready)
  );

  sync_fifo #(
    .width      (kernel_pkg::axi_id_w + kernel_pkg::axi_resp_w),
    .depth_log2 (kernel_pkg::fifo_depth_log2)
  ) b_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  ({bid, bresp}),
    .wready (bready), // stall the link once responses pile up
    .rvalid (b_valid),
    .rdata  (b_rdata),
    .rready (b_pop)
  );

  assign {awsize, awaddr} = aw_rdata;
  assign {wstrb, wdata}   = w_rdata;
  assign {b_id, b_resp}   = b_rdata;

  // single-beat INCR bursts only
  assign awburst = kernel_pkg::axi_burst_incr;
  assign awlen   = kernel_pkg::axi_len_single;
  assign awid    = kernel_pkg::axi_awid;
  assign wlast   = 1'b1;

endmodule

`default_nettype wire

/* source/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module host_regs (
  input  wire logic                                    clk,
  input  wire logic                                    rstn,
  input  wire logic                                    host_en,
  input  wire logic [3:0]                              host_we,
  input  wire logic [kernel_pkg::addr_w-1:0]           host_addr,
  input  wire logic [kernel_pkg::word_w-1:0]           host_din,
  output logic [kernel_pkg::word_w-1:0]                host_dout,
  output logic                                         aw_push,
  output logic                                         w_push,
  output kernel_pkg::staging_t                         stage,
  output logic                                         b_pop,
  input  wire logic                                    b_valid,
  input  wire logic [kernel_pkg::axi_id_w-1:0]         b_id,
  input  wire logic [kernel_pkg::axi_resp_w-1:0]       b_resp,
  output logic                                         lba_wr,
  output logic                                         dptr_wr,
  output logic                                         cmd_wr,
  output logic                                         submit,
  output logic                                         sq_clear,
  output logic                                         sq_pop,
  output logic [kernel_pkg::word_w-1:0]                field,
  input  wire logic [15:0]                             command_id,
  input  wire logic [15:0]                             head_ptr,
  input  wire logic                                    pop_valid,
  input  wire logic [kernel_pkg::sqe_w-1:0]            pop_entry
);

  logic wr;
  logic rd;
  logic stage_sel;
  logic [2:0] stage_idx;

  assign wr = host_en && host_we != 4'b0000;
  assign rd = host_en && host_we == 4'b0000;

  // 0x00..0x1c hit the staging words
  assign stage_sel = host_addr[kernel_pkg::addr_w-1:5] ==
                     kernel_pkg::reg_stage_base[kernel_pkg::addr_w-1:5];
  assign stage_idx = host_addr[4:2];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      b_pop    <= 1'b0;
      lba_wr   <= 1'b0;
      dptr_wr  <= 1'b0;
      cmd_wr   <= 1'b0;
      submit   <= 1'b0;
      sq_clear <= 1'b0;
      sq_pop   <= 1'b0;
    end else begin
      aw_push  <= wr && host_addr == kernel_pkg::reg_aw_push;
      w_push   <= wr && host_addr == kernel_pkg::reg_w_push;
      b_pop    <= wr && host_addr == kernel_pkg::reg_b_pop && b_valid;
      lba_wr   <= wr && host_addr == kernel_pkg::reg_lba;
      dptr_wr  <= wr && host_addr == kernel_pkg::reg_dptr;
      cmd_wr   <= wr && host_addr == kernel_pkg::reg_cmd;
      submit   <= wr && host_addr == kernel_pkg::reg_submit;
      sq_clear <= wr && host_addr == kernel_pkg::reg_sq_clear;
      sq_pop   <= wr && host_addr == kernel_pkg::reg_sq_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_valid) begin
      stage.raw <= 256'(pop_entry); // sqe view, padding cleared
    end else if (wr) begin
      if (stage_sel) begin
        stage.raw[stage_idx] <= host_din;
      end else if (host_addr == kernel_pkg::reg_b_pop && b_valid) begin
        // head response taken now, FIFO pops next cycle
        stage.b.pad  <= '0;
        stage.b.id   <= b_id;
        stage.b.resp <= b_resp;
      end
    end
    if (wr) field <= host_din;
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      if (stage_sel) begin
        host_dout <= stage.raw[stage_idx];
      end else if (host_addr == kernel_pkg::reg_b_status) begin
        host_dout <= {31'b0, b_valid};
      end else if (host_addr == kernel_pkg::reg_sq_ptr) begin
        host_dout <= {command_id, head_ptr};
      end
    end
  end

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int width      = 8,
  parameter int depth_log2 = 4
) (
  input  wire logic             clk,
  input  wire logic             rstn,
  input  wire logic             wvalid,
  input  wire logic [width-1:0] wdata,
  output logic                  wready,
  output logic                  rvalid,
  output logic [width-1:0]      rdata,
  input  wire logic             rready
);

  logic [width-1:0]      mem [2**depth_log2];
  logic [depth_log2-1:0] wptr;
  logic [depth_log2-1:0] rptr;
  logic [depth_log2:0]   count; // entries behind the head register
  logic                  load;
  logic                  do_wr;
  logic                  push_mem;
  logic                  pull_mem;

  assign wready   = (count + rvalid) != (2**depth_log2);
  assign load     = !rvalid || rready; // head is free this cycle
  assign do_wr    = wvalid && wready;
  assign pull_mem = load && count != '0;
  assign push_mem = do_wr && !(load && count == '0); // else straight to head

  always_ff @(posedge clk) begin
    if (push_mem) mem[wptr] <= wdata;
    if (load) rdata <= (count != '0) ? mem[rptr] : wdata;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr   <= '0;
      rptr   <= '0;
      count  <= '0;
      rvalid <= 1'b0;
    end else begin
      if (push_mem) wptr <= wptr + 1'b1;
      if (pull_mem) rptr <= rptr + 1'b1;
      count <= count + push_mem - pull_mem;
      if (load) rvalid <= count != '0 || do_wr;
    end
  end

endmodule

`default_nettype wire

/* source/kernel_pkg.sv */
`default_nettype none

package kernel_pkg;

  localparam int addr_w = 15;
  localparam int word_w = 32;

  localparam int axi_addr_w = 64;
  localparam int axi_data_w = 128;
  localparam int axi_strb_w = 16;
  localparam int axi_id_w   = 4;
  localparam int axi_resp_w = 2;
  localparam int axi_size_w = 3;

  localparam logic [axi_id_w-1:0] axi_awid       = 4'd1;
  localparam logic [1:0]          axi_burst_incr = 2'b01;
  localparam logic [7:0]          axi_len_single = 8'd0; // one beat per burst

  // host register map
  localparam logic [addr_w-1:0] reg_stage_base = 15'h000;
  localparam logic [addr_w-1:0] reg_aw_push    = 15'h020;
  localparam logic [addr_w-1:0] reg_w_push     = 15'h030;
  localparam logic [addr_w-1:0] reg_b_status   = 15'h050;
  localparam logic [addr_w-1:0] reg_b_pop      = 15'h054;
  localparam logic [addr_w-1:0] reg_lba        = 15'h100;
  localparam logic [addr_w-1:0] reg_dptr       = 15'h104;
  localparam logic [addr_w-1:0] reg_cmd        = 15'h108;
  localparam logic [addr_w-1:0] reg_submit     = 15'h110;
  localparam logic [addr_w-1:0] reg_sq_clear   = 15'h114;
  localparam logic [addr_w-1:0] reg_sq_pop     = 15'h200;
  localparam logic [addr_w-1:0] reg_sq_ptr     = 15'h204;

  localparam logic [word_w-1:0] nvme_nsid = 32'd1;

  localparam int fifo_depth_log2 = 4;
  localparam int sq_depth_log2   = 4;
  localparam int sqe_w           = 144; // nlb + lba + dptr + nsid + cdw0

  // one staging word, read as whichever queue entry it feeds
  typedef union packed {
    logic [7:0][word_w-1:0] raw;
    struct packed {
      logic [256-axi_size_w-axi_addr_w-1:0] pad;
      logic [axi_size_w-1:0]                size;
      logic [axi_addr_w-1:0]                addr;
    } aw;
    struct packed {
      logic [256-axi_strb_w-axi_data_w-1:0] pad;
      logic [axi_strb_w-1:0]                strb;
      logic [axi_data_w-1:0]                data;
    } w;
    struct packed {
      logic [256-axi_id_w-axi_resp_w-1:0] pad;
      logic [axi_id_w-1:0]                id;
      logic [axi_resp_w-1:0]              resp;
    } b;
    struct packed {
      logic [256-sqe_w-1:0] pad;
      logic [15:0]          nlb;
      logic [word_w-1:0]    lba;
      logic [word_w-1:0]    dptr;
      logic [word_w-1:0]    nsid;
      logic [word_w-1:0]    cdw0;
    } sqe;
  } staging_t;

endpackage

`default_nettype wire
